//--- verilog/mmio_settings.svh
`ifndef MMIO_SETTINGS_SVH
`define MMIO_SETTINGS_SVH

// Width of one screen coordinate
`define MMIO_COORD_BITS 7

// Signed vertical velocity width
`define MMIO_VEL_BITS 10

// Arena limits, y grows downward so the floor is the largest y
`define MMIO_ARENA_X_MAX 120
`define MMIO_FLOOR_Y 100

// Data memory word address width (1024 words)
`define MMIO_DMEM_ADDR_BITS 10

`endif

//--- verilog/mmio_map_pkg.sv
package mmio_map_pkg;

	// Coprocessor unit select, address bits 11:7
	typedef enum logic [4:0] {
		UNIT_PHYS_P1   = 5'd0,
		UNIT_PHYS_P2   = 5'd1,
		UNIT_COLLISION = 5'd12
	} unit_e;

	// Register index inside a physics unit, address bits 6:2
	typedef enum logic [4:0] {
		REG_START   = 5'd0, // Start position, loads at once
		REG_GRAVITY = 5'd1, // Signed 8 bits
		REG_STEP_X  = 5'd2, // Signed 8 bits
		REG_SIZE    = 5'd3,
		REG_ATTACK  = 5'd4  // Bit 0 only
	} phys_reg_e;

	// Address field positions
	localparam int REGION_BIT = 12; // Set selects coprocessor space
	localparam int UNIT_MSB   = 11;
	localparam int UNIT_LSB   = 7;
	localparam int REG_MSB    = 6;
	localparam int REG_LSB    = 2;

endpackage

//--- verilog/game_pkg.sv
`include "mmio_settings.svh"

package game_pkg;

	// One unsigned screen coordinate
	typedef logic [`MMIO_COORD_BITS-1:0] coord_t;

	// Packed position, x in the low bits and y in the high bits.
	// Box sizes reuse it with width in x and height in y.
	typedef struct packed {
		coord_t y;
		coord_t x;
	} pos_t;

	// Bit positions in the 4-bit wall word
	typedef enum logic [1:0] {
		WALL_LEFT    = 2'd0,
		WALL_RIGHT   = 2'd1,
		WALL_CEILING = 2'd2,
		WALL_FLOOR   = 2'd3
	} wall_bit_e;

	// Bit positions in the 4-bit collision word
	typedef enum logic [1:0] {
		COLL_OVERLAP  = 2'd0, // Boxes intersect
		COLL_P1_LEFT  = 2'd1, // P1 x below P2 x
		COLL_P1_ABOVE = 2'd2, // P1 y below P2 y
		COLL_HIT      = 2'd3  // Overlap while either player attacks
	} coll_bit_e;

endpackage

//--- verilog/physics_unit.sv
`timescale 1ns/10ps
`include "mmio_settings.svh"

module physics_unit (
	input  logic clock,
	input  logic reset,
	input  logic frame,
	input  logic load_start,
	input  game_pkg::pos_t start_pos,
	input  logic signed [7:0] gravity,
	input  logic signed [7:0] step_x,
	output game_pkg::pos_t position,
	output logic [3:0] wall
);
	localparam int CW = `MMIO_COORD_BITS;
	localparam int VW = `MMIO_VEL_BITS;
	localparam int WW = VW + 2; // Wide enough for any coordinate sum

	localparam logic signed [VW:0] VEL_MAX = (2 ** (VW - 1)) - 1;
	localparam logic signed [VW:0] VEL_MIN = -(2 ** (VW - 1));
	localparam logic signed [WW-1:0] X_LIMIT = `MMIO_ARENA_X_MAX;
	localparam logic signed [WW-1:0] Y_LIMIT = `MMIO_FLOOR_Y;

	logic signed [VW-1:0] vel;
	logic signed [VW:0] vel_sum;
	logic signed [VW-1:0] vel_sat;
	logic signed [VW-1:0] vel_next;
	logic signed [WW-1:0] x_wide;
	logic signed [WW-1:0] y_wide;
	game_pkg::pos_t pos_next;
	logic [3:0] wall_next;
	logic step;

	// Start load takes priority over the frame step
	assign step = frame && !load_start;

	// Gravity accumulates into the velocity with saturation
	assign vel_sum = vel + gravity;

	always_comb begin
		if (vel_sum > VEL_MAX)
			vel_sat = VEL_MAX[VW-1:0];
		else if (vel_sum < VEL_MIN)
			vel_sat = VEL_MIN[VW-1:0];
		else
			vel_sat = vel_sum[VW-1:0];
	end

	assign x_wide = $signed({1'b0, position.x}) + step_x;
	assign y_wide = $signed({1'b0, position.y}) + vel_sat;

	// Arena clamping, wall word rebuilt from scratch every step
	always_comb begin
		wall_next = 4'b0000;
		vel_next = vel_sat;

		if (x_wide < 0) begin
			pos_next.x = '0;
			wall_next[game_pkg::WALL_LEFT] = 1'b1;
		end else if (x_wide > X_LIMIT) begin
			pos_next.x = X_LIMIT[CW-1:0];
			wall_next[game_pkg::WALL_RIGHT] = 1'b1;
		end else begin
			pos_next.x = x_wide[CW-1:0];
		end

		if (y_wide < 0) begin
			pos_next.y = '0;
			wall_next[game_pkg::WALL_CEILING] = 1'b1;
			vel_next = '0; // Bumped the ceiling
		end else if (y_wide > Y_LIMIT) begin
			pos_next.y = Y_LIMIT[CW-1:0];
			wall_next[game_pkg::WALL_FLOOR] = 1'b1;
			vel_next = '0; // Landed
		end else begin
			pos_next.y = y_wide[CW-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			position <= '0;
			vel <= '0;
			wall <= 4'b0000;
		end else if (load_start) begin
			position <= start_pos;
			vel <= '0;
			wall <= 4'b0000;
		end else if (frame) begin
			position <= pos_next;
			vel <= vel_next;
			wall <= wall_next;
		end
	end

	// A step never leaves the player outside the arena
	assert property (@(posedge clock) disable iff (reset)
		step |=> (position.x <= X_LIMIT[CW-1:0]) && (position.y <= Y_LIMIT[CW-1:0]));

	// Landing on the floor always stops the fall
	assert property (@(posedge clock) disable iff (reset)
		$rose(wall[game_pkg::WALL_FLOOR]) |-> (vel == '0));

endmodule

//--- verilog/overlap_detect.sv
`timescale 1ns/10ps

module overlap_detect (
	input  logic clock,
	input  logic reset,
	input  game_pkg::pos_t pos_a,
	input  game_pkg::pos_t pos_b,
	input  game_pkg::pos_t size_a,
	input  game_pkg::pos_t size_b,
	input  logic attack_a,
	input  logic attack_b,
	output logic [3:0] coll
);
	localparam int CW = $bits(game_pkg::coord_t);

	logic [CW:0] a_x_end, a_y_end; // One extra bit for the carry
	logic [CW:0] b_x_end, b_y_end;
	logic x_hit, y_hit;
	logic [3:0] coll_next;

	assign a_x_end = pos_a.x + size_a.x;
	assign a_y_end = pos_a.y + size_a.y;
	assign b_x_end = pos_b.x + size_b.x;
	assign b_y_end = pos_b.y + size_b.y;

	// Each box starts before the other one ends, on both axes
	assign x_hit = ({1'b0, pos_a.x} < b_x_end) && ({1'b0, pos_b.x} < a_x_end);
	assign y_hit = ({1'b0, pos_a.y} < b_y_end) && ({1'b0, pos_b.y} < a_y_end);

	always_comb begin
		coll_next = 4'b0000;
		coll_next[game_pkg::COLL_OVERLAP] = x_hit && y_hit;
		coll_next[game_pkg::COLL_P1_LEFT] = pos_a.x < pos_b.x;
		coll_next[game_pkg::COLL_P1_ABOVE] = pos_a.y < pos_b.y;
		coll_next[game_pkg::COLL_HIT] = x_hit && y_hit && (attack_a || attack_b);
	end

	always_ff @(posedge clock) begin
		if (reset)
			coll <= 4'b0000;
		else
			coll <= coll_next;
	end

	// An attack only counts when the boxes touch
	assert property (@(posedge clock) disable iff (reset)
		coll[game_pkg::COLL_HIT] |-> coll[game_pkg::COLL_OVERLAP]);

endmodule

//--- verilog/data_mem.sv
`timescale 1ns/10ps
`include "mmio_settings.svh"

module data_mem (
	input  logic clock,
	input  logic [`MMIO_DMEM_ADDR_BITS-1:0] addr,
	input  logic [31:0] wdata,
	input  logic we,
	output logic [31:0] rdata
);
	localparam int DEPTH = 2 ** `MMIO_DMEM_ADDR_BITS;

	logic [31:0] mem [DEPTH];

	// Write at the edge, read data registered for one cycle of latency.
	// A read of the word being written returns the old contents.
	always_ff @(posedge clock) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

	// Writes must land at a known word
	assert property (@(posedge clock) we |-> !$isunknown(addr));

endmodule

//--- verilog/mmio.sv
`timescale 1ns/10ps
`include "mmio_settings.svh"

module mmio (
	input  logic clock,
	input  logic reset,
	input  logic [12:0] address,
	input  logic [31:0] data_in,
	input  logic wren,
	input  logic frame,
	output logic [31:0] data_out
);
	localparam int RB = mmio_map_pkg::REGION_BIT;
	localparam int AW = `MMIO_DMEM_ADDR_BITS;

	// Address fields
	logic region_io;
	logic [4:0] unit_sel;
	logic [4:0] reg_sel;

	// Write decode
	logic io_write;
	logic [1:0] phys_write; // One per player
	logic [1:0] load_start;
	logic dmem_we;
	game_pkg::pos_t start_pos;

	// Per-player control registers
	logic signed [7:0] gravity_r [2];
	logic signed [7:0] step_x_r [2];
	game_pkg::pos_t size_r [2];
	logic [1:0] attack_r;

	// Unit results
	game_pkg::pos_t pos_p1, pos_p2;
	logic [3:0] wall_p1, wall_p2;
	logic [3:0] coll;

	// Readback path
	logic [31:0] unit_word;
	logic [31:0] unit_q;
	logic region_q;
	logic [31:0] dmem_rdata;

	assign region_io = address[RB];
	assign unit_sel = address[mmio_map_pkg::UNIT_MSB:mmio_map_pkg::UNIT_LSB];
	assign reg_sel = address[mmio_map_pkg::REG_MSB:mmio_map_pkg::REG_LSB];

	assign io_write = wren && region_io;
	assign dmem_we = wren && !region_io;

	assign phys_write[0] = io_write && (unit_sel == mmio_map_pkg::UNIT_PHYS_P1);
	assign phys_write[1] = io_write && (unit_sel == mmio_map_pkg::UNIT_PHYS_P2);

	// Start writes bypass storage and load the unit directly
	assign load_start[0] = phys_write[0] && (reg_sel == mmio_map_pkg::REG_START);
	assign load_start[1] = phys_write[1] && (reg_sel == mmio_map_pkg::REG_START);
	assign start_pos = game_pkg::pos_t'(data_in[13:0]);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int p = 0; p < 2; p++) begin
				gravity_r[p] <= '0;
				step_x_r[p] <= '0;
				size_r[p] <= '0;
			end
			attack_r <= 2'b00;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (phys_write[p]) begin
					case (reg_sel)
						mmio_map_pkg::REG_GRAVITY: gravity_r[p] <= $signed(data_in[7:0]);
						mmio_map_pkg::REG_STEP_X:  step_x_r[p] <= $signed(data_in[7:0]);
						mmio_map_pkg::REG_SIZE:    size_r[p] <= game_pkg::pos_t'(data_in[13:0]);
						mmio_map_pkg::REG_ATTACK:  attack_r[p] <= data_in[0];
						default: ; // Start handled above, rest unmapped
					endcase
				end
			end
		end
	end

	physics_unit phys_p1 (
		.clock(clock),
		.reset(reset),
		.frame(frame),
		.load_start(load_start[0]),
		.start_pos(start_pos),
		.gravity(gravity_r[0]),
		.step_x(step_x_r[0]),
		.position(pos_p1),
		.wall(wall_p1)
	);

	physics_unit phys_p2 (
		.clock(clock),
		.reset(reset),
		.frame(frame),
		.load_start(load_start[1]),
		.start_pos(start_pos),
		.gravity(gravity_r[1]),
		.step_x(step_x_r[1]),
		.position(pos_p2),
		.wall(wall_p2)
	);

	overlap_detect collide (
		.clock(clock),
		.reset(reset),
		.pos_a(pos_p1),
		.pos_b(pos_p2),
		.size_a(size_r[0]),
		.size_b(size_r[1]),
		.attack_a(attack_r[0]),
		.attack_b(attack_r[1]),
		.coll(coll)
	);

	data_mem dmem (
		.clock(clock),
		.addr(address[AW-1:0]),
		.wdata(data_in),
		.we(dmem_we),
		.rdata(dmem_rdata)
	);

	// Unit readback, physics units ignore the register index
	always_comb begin
		unit_word = 32'd0;
		case (unit_sel)
			mmio_map_pkg::UNIT_PHYS_P1:   unit_word = {14'd0, wall_p1, pos_p1};
			mmio_map_pkg::UNIT_PHYS_P2:   unit_word = {14'd0, wall_p2, pos_p2};
			mmio_map_pkg::UNIT_COLLISION: unit_word = {28'd0, coll};
			default: unit_word = 32'd0;
		endcase
	end

	// Matches the one-cycle latency of the memory read
	always_ff @(posedge clock) begin
		if (reset) begin
			unit_q <= 32'd0;
			region_q <= 1'b1; // Select the cleared unit word while in reset
		end else begin
			unit_q <= unit_word;
			region_q <= region_io;
		end
	end

	assign data_out = region_q ? unit_q : dmem_rdata;

	// Coprocessor writes never reach the memory
	assert property (@(posedge clock) disable iff (reset)
		address[RB] |-> !dmem.we);

endmodule

//--- sim/mmio_tb.sv
`timescale 1ns/10ps
`include "mmio_settings.svh"

module mmio_tb;
	localparam int OP_WRITE = 0;
	localparam int OP_READ = 1;
	localparam int OP_FRAME = 2;
	localparam int OP_START_FRAME = 3; // Start write and frame on one edge
	localparam int VEL_HI = (1 << (`MMIO_VEL_BITS - 1)) - 1;
	localparam int VEL_LO = -(1 << (`MMIO_VEL_BITS - 1));

	logic clock;
	logic reset;
	logic [12:0] address;
	logic [31:0] data_in;
	logic wren;
	logic frame;
	logic [31:0] data_out;

	// Operation table
	int op_kind[$];
	logic [12:0] op_addr[$];
	logic [31:0] op_data[$];
	logic [31:0] op_exp[$];
	string op_name[$];
	logic table_ready = 1'b0;

	// Reference model state, one entry per player
	int m_x[2], m_y[2], m_vel[2], m_grav[2], m_step[2], m_w[2], m_h[2];
	logic [3:0] m_wall[2];
	logic m_att[2];
	logic [31:0] mem_model [1024];
	logic [19:0] lfsr_state = 20'd69504;

	mmio mmio_i (
		.clock(clock),
		.reset(reset),
		.address(address),
		.data_in(data_in),
		.wren(wren),
		.frame(frame),
		.data_out(data_out)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	// x^20 + x^17 + 1
	function automatic logic [19:0] lfsr_next(logic [19:0] s);
		return {s[18:0], s[19] ^ s[16]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] val);
		val = 32'd0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	// Region bit, unit in 11:7, register in 6:2
	function automatic logic [12:0] io_addr(int unit, int regi);
		return {1'b1, unit[4:0], regi[4:0], 2'b00};
	endfunction

	task automatic add_op(input int kind, input logic [12:0] addr, input logic [31:0] data,
			input logic [31:0] exp, input string name);
		op_kind.push_back(kind);
		op_addr.push_back(addr);
		op_data.push_back(data);
		op_exp.push_back(exp);
		op_name.push_back(name);
	endtask

	// One frame of the step rule for one player
	task automatic model_step(input int p);
		int v;
		int nx;
		int ny;
		v = m_vel[p] + m_grav[p];
		if (v > VEL_HI)
			v = VEL_HI;
		else if (v < VEL_LO)
			v = VEL_LO;
		nx = m_x[p] + m_step[p];
		ny = m_y[p] + v;
		m_wall[p] = 4'b0000;
		if (nx < 0) begin
			nx = 0;
			m_wall[p][0] = 1'b1;
		end else if (nx > `MMIO_ARENA_X_MAX) begin
			nx = `MMIO_ARENA_X_MAX;
			m_wall[p][1] = 1'b1;
		end
		if (ny < 0) begin
			ny = 0;
			m_wall[p][2] = 1'b1;
			v = 0;
		end else if (ny > `MMIO_FLOOR_Y) begin
			ny = `MMIO_FLOOR_Y;
			m_wall[p][3] = 1'b1;
			v = 0;
		end
		m_x[p] = nx;
		m_y[p] = ny;
		m_vel[p] = v;
	endtask

	function automatic logic [31:0] unit_word(int p);
		return {14'd0, m_wall[p], m_y[p][6:0], m_x[p][6:0]};
	endfunction

	function automatic logic [31:0] coll_word();
		logic ov;
		ov = (m_x[0] < m_x[1] + m_w[1]) && (m_x[1] < m_x[0] + m_w[0]) &&
			(m_y[0] < m_y[1] + m_h[1]) && (m_y[1] < m_y[0] + m_h[0]);
		return {28'd0, ov && (m_att[0] || m_att[1]), m_y[0] < m_y[1], m_x[0] < m_x[1], ov};
	endfunction

	task automatic write_reg(input int p, input int regi, input logic [31:0] value,
			input string name);
		add_op(OP_WRITE, io_addr(p, regi), value, 32'd0, name);
		case (regi)
			1: m_grav[p] = $signed(value[7:0]);
			2: m_step[p] = $signed(value[7:0]);
			3: begin
				m_w[p] = value[6:0];
				m_h[p] = value[13:7];
			end
			4: m_att[p] = value[0];
			default: ;
		endcase
	endtask

	task automatic load_start(input int p, input int x, input int y, input bit with_frame,
			input string name);
		if (with_frame)
			model_step(1 - p); // Only the other player steps
		m_x[p] = x;
		m_y[p] = y;
		m_vel[p] = 0;
		m_wall[p] = 4'b0000;
		add_op(with_frame ? OP_START_FRAME : OP_WRITE, io_addr(p, 0),
			(y << 7) | x, 32'd0, name);
	endtask

	task automatic frame_pulse(input string name);
		model_step(0);
		model_step(1);
		add_op(OP_FRAME, 13'd0, 32'd0, 32'd0, name);
	endtask

	task automatic expect_unit(input int p, input string name);
		add_op(OP_READ, io_addr(p, p + 1), 32'd0, unit_word(p), name);
	endtask

	task automatic expect_coll(input string name);
		add_op(OP_READ, io_addr(12, 0), 32'd0, coll_word(), name);
	endtask

	task automatic build_table();
		logic [31:0] a;
		logic [31:0] d;
		logic [9:0] mem_addrs[$];
		for (int p = 0; p < 2; p++) begin
			m_x[p] = 0;
			m_y[p] = 0;
			m_vel[p] = 0;
			m_grav[p] = 0;
			m_step[p] = 0;
			m_w[p] = 0;
			m_h[p] = 0;
			m_wall[p] = 4'b0000;
			m_att[p] = 1'b0;
		end
		expect_unit(0, "reset_p1");
		expect_unit(1, "reset_p2");
		expect_coll("reset_coll");

		for (int i = 0; i < 32; i++) begin
			random_bits(10, a);
			random_bits(32, d);
			mem_model[a[9:0]] = d;
			mem_addrs.push_back(a[9:0]);
			add_op(OP_WRITE, {3'b000, a[9:0]}, d, 32'd0, $sformatf("mem_wr_%0d", i));
		end
		foreach (mem_addrs[i])
			add_op(OP_READ, {3'b000, mem_addrs[i]}, 32'd0, mem_model[mem_addrs[i]],
				$sformatf("mem_rd_%0d", i));

		// Unmapped unit 5 shares low bits with memory word 0x280
		add_op(OP_WRITE, 13'h0280, 32'h1234_abcd, 32'd0, "mem_wr_280");
		add_op(OP_WRITE, io_addr(5, 0), 32'hdead_beef, 32'd0, "io_wr_unmapped");
		add_op(OP_READ, 13'h0280, 32'd0, 32'h1234_abcd, "mem_undisturbed");
		add_op(OP_READ, io_addr(5, 0), 32'd0, 32'd0, "unmapped_zero");

		write_reg(0, 1, 32'd3, "p1_gravity");
		write_reg(0, 2, 32'd5, "p1_step");
		load_start(0, 10, 20, 1'b0, "p1_start");
		expect_unit(0, "p1_start_rd");
		for (int i = 0; i < 4; i++)
			frame_pulse("fall_frame");
		expect_unit(0, "p1_after_fall");
		expect_unit(1, "p2_idle");

		// Left wall for player 2, floor for player 1
		write_reg(1, 2, 32'hce, "p2_step_neg");
		load_start(1, 60, 40, 1'b0, "p2_start");
		for (int i = 0; i < 3; i++) begin
			frame_pulse("clamp_frame");
			expect_unit(0, $sformatf("p1_clamp_%0d", i));
			expect_unit(1, $sformatf("p2_clamp_%0d", i));
		end
		write_reg(0, 1, 32'd0, "p1_gravity_off");
		write_reg(0, 2, 32'd0, "p1_step_off");
		frame_pulse("rest_frame");
		expect_unit(0, "p1_on_floor");

		write_reg(0, 3, (10 << 7) | 10, "p1_size");
		write_reg(1, 3, (10 << 7) | 10, "p2_size");
		load_start(0, 10, 10, 1'b0, "p1_place");
		load_start(1, 50, 50, 1'b0, "p2_apart");
		expect_unit(0, "p1_place_rd");
		expect_unit(1, "p2_apart_rd");
		expect_coll("coll_apart");
		load_start(1, 15, 12, 1'b0, "p2_near");
		expect_unit(0, "p1_place_rd2");
		expect_unit(1, "p2_near_rd");
		expect_coll("coll_overlap");
		write_reg(1, 4, 32'd1, "p2_attack");
		expect_unit(0, "p1_place_rd3");
		expect_unit(1, "p2_near_rd2");
		expect_coll("coll_hit");

		// P1 would move on this frame, so a step applied to the start shows up
		write_reg(0, 1, 32'd2, "p1_gravity_on");
		write_reg(0, 2, 32'd4, "p1_step_on");
		load_start(0, 30, 40, 1'b1, "p1_start_frame");
		expect_unit(0, "p1_start_wins");
		expect_unit(1, "p2_stepped");
		table_ready = 1'b1;
	endtask

	initial begin
		reset = 1'b1;
		address = 13'd0;
		data_in = 32'd0;
		wren = 1'b0;
		frame = 1'b0;
		build_table();
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		foreach (op_kind[i]) begin
			address = op_addr[i];
			data_in = op_data[i];
			wren = (op_kind[i] == OP_WRITE) || (op_kind[i] == OP_START_FRAME);
			frame = (op_kind[i] == OP_FRAME) || (op_kind[i] == OP_START_FRAME);
			@(negedge clock); // data_out settled after the rising edge
			if (op_kind[i] == OP_READ)
				check_value(op_name[i], op_exp[i], data_out);
		end
		wren = 1'b0;
		frame = 1'b0;
		$display("Testbench passed");
		$finish;
	end

	// Four cycles per table entry plus reset
	initial begin
		longint limit_ns;
		wait (table_ready);
		limit_ns = (longint'(op_kind.size()) * 4 + 8) * 100;
		#(limit_ns);
		$display("Timed out after %0d ns without finishing the operation table", limit_ns);
		$display("Testbench failed");
		$fatal(1);
	end

endmodule

//--- build.f
+incdir+verilog
verilog/mmio_map_pkg.sv
verilog/game_pkg.sv
verilog/physics_unit.sv
verilog/overlap_detect.sv
verilog/data_mem.sv
verilog/mmio.sv
sim/mmio_tb.sv
